// ==== hw/cmd_pkg.sv ====
`default_nettype none

package cmd_pkg;

	typedef logic [31:0] arg_t;

	// ids on the host link
	typedef enum logic [4:0] {
		cmd_get_version = 5'd0,
		cmd_get_time = 5'd2,
		cmd_set_digital_out = 5'd15,
		cmd_config_digital_out = 5'd16,
		cmd_shutdown = 5'd19
	} cmd_e;

	typedef enum logic [7:0] {
		rsp_get_version = 8'd0,
		rsp_get_time = 8'd1
	} rsp_e;

	typedef enum logic {
		unit_system,
		unit_gpio
	} unit_e;

	localparam int MAX_ARGS = 4;

	typedef logic [2:0] nargs_t;

	typedef struct packed {
		unit_e unit;
		nargs_t nargs;
		logic has_response;
	} cmd_entry_t;

	function automatic cmd_entry_t cmd_lookup(input logic [7:0] id);
		cmd_entry_t e;
		// unknown ids land on gpio, which drops them
		e = '{unit_gpio, 3'd0, 1'b0};
		case (id)
			cmd_get_version: e = '{unit_system, 3'd0, 1'b1};
			cmd_get_time: e = '{unit_system, 3'd0, 1'b1};
			cmd_shutdown: e = '{unit_system, 3'd0, 1'b0};
			cmd_set_digital_out: e = '{unit_gpio, 3'd2, 1'b0};
			cmd_config_digital_out: e = '{unit_gpio, 3'd2, 1'b0};
			default: e = '{unit_gpio, 3'd0, 1'b0};
		endcase
		return e;
	endfunction

endpackage

`default_nettype wire

// ==== hw/vlq_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module vlq_decoder import cmd_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [7:0] msg_data,
	input logic msg_ready,
	output logic msg_rd_en,
	input logic busy,
	output cmd_e cmd,
	output cmd_entry_t entry,
	output arg_t arg_data,
	output logic arg_valid,
	output logic cmd_valid
);

	typedef enum logic [1:0] {
		st_idle,
		st_arg_start,
		st_arg_cont,
		st_wait
	} state_e;

	state_e state;
	nargs_t arg_cnt;
	cmd_entry_t lookup;
	logic pop;
	logic last_arg;

	assign lookup = cmd_lookup(msg_data);
	// never two pops back to back
	assign pop = msg_ready && !msg_rd_en && state != st_wait;
	assign last_arg = arg_cnt + 3'd1 == entry.nargs || arg_cnt + 3'd1 == MAX_ARGS;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			msg_rd_en <= 1'b0;
			arg_valid <= 1'b0;
			cmd_valid <= 1'b0;
			arg_cnt <= '0;
		end else begin
			msg_rd_en <= pop;
			arg_valid <= 1'b0;
			cmd_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (pop) begin
						arg_cnt <= '0;
						if (lookup.nargs == 3'd0) begin
							cmd_valid <= 1'b1;
							state <= st_wait;
						end else begin
							state <= st_arg_start;
						end
					end
				end
				st_arg_start, st_arg_cont: begin
					if (pop && msg_data[7]) begin
						state <= st_arg_cont;
					end else if (pop) begin
						arg_valid <= 1'b1;
						arg_cnt <= arg_cnt + 3'd1;
						if (last_arg) begin
							cmd_valid <= 1'b1;
							state <= st_wait;
						end else begin
							state <= st_arg_start;
						end
					end
				end
				// cmd_valid covers the cycle before busy rises
				st_wait: begin
					if (!cmd_valid && !busy)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && pop) begin
			entry <= lookup;
			// ids above 31 get a code no unit knows
			cmd <= (msg_data[7:5] == 3'd0) ? cmd_e'(msg_data[4:0]) : cmd_e'(5'h1f);
		end
		// first byte sign extends when bits 6:5 are both set
		if (state == st_arg_start && pop)
			arg_data <= {{25{&msg_data[6:5]}}, msg_data[6:0]};
		if (state == st_arg_cont && pop)
			arg_data <= {arg_data[24:0], msg_data[6:0]};
	end

endmodule

`default_nettype wire

// ==== hw/cmd_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch import cmd_pkg::*; (
	input logic clk,
	input logic rst,
	input cmd_e cmd,
	input cmd_entry_t entry,
	input arg_t arg_data,
	input logic arg_valid,
	input logic cmd_valid,
	output logic busy,
	output cmd_e ucmd,
	output arg_t uarg,
	output logic sys_cmd_ready,
	output logic gpio_cmd_ready,
	input logic sys_arg_advance,
	input logic gpio_arg_advance,
	input arg_t sys_param_data,
	input arg_t gpio_param_data,
	input logic sys_param_write,
	input logic gpio_param_write,
	input logic sys_cmd_done,
	input logic gpio_cmd_done,
	output arg_t enc_params [4],
	output logic [2:0] enc_nparams,
	output logic enc_start,
	input logic enc_busy
);

	localparam int PTR_BITS = $clog2(MAX_ARGS);

	typedef enum logic [1:0] {
		s_idle,
		s_run,
		s_enc
	} state_e;

	state_e state;
	arg_t args [MAX_ARGS];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	unit_e unit;
	logic has_response;
	logic sel_advance;
	logic sel_write;
	logic sel_done;
	arg_t sel_param;

	assign busy = state != s_idle;
	// next argument is visible the cycle after an advance
	assign uarg = args[rd_ptr];

	always_comb begin
		if (unit == unit_system) begin
			sel_advance = sys_arg_advance;
			sel_write = sys_param_write;
			sel_done = sys_cmd_done;
			sel_param = sys_param_data;
		end else begin
			sel_advance = gpio_arg_advance;
			sel_write = gpio_param_write;
			sel_done = gpio_cmd_done;
			sel_param = gpio_param_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_idle;
			sys_cmd_ready <= 1'b0;
			gpio_cmd_ready <= 1'b0;
			enc_start <= 1'b0;
			enc_nparams <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			unit <= unit_system;
			has_response <= 1'b0;
		end else begin
			sys_cmd_ready <= 1'b0;
			gpio_cmd_ready <= 1'b0;
			enc_start <= 1'b0;
			if (arg_valid)
				wr_ptr <= wr_ptr + 1'b1;
			case (state)
				s_idle: begin
					if (cmd_valid) begin
						wr_ptr <= '0;
						rd_ptr <= '0;
						enc_nparams <= '0;
						unit <= entry.unit;
						has_response <= entry.has_response;
						sys_cmd_ready <= entry.unit == unit_system;
						gpio_cmd_ready <= entry.unit == unit_gpio;
						state <= s_run;
					end
				end
				s_run: begin
					if (sel_advance)
						rd_ptr <= rd_ptr + 1'b1;
					if (sel_write && enc_nparams != 3'd4)
						enc_nparams <= enc_nparams + 3'd1;
					if (sel_done) begin
						enc_start <= has_response;
						state <= has_response ? s_enc : s_idle;
					end
				end
				s_enc: begin
					if (!enc_start && !enc_busy)
						state <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (arg_valid)
			args[wr_ptr] <= arg_data;
		if (state == s_idle && cmd_valid)
			ucmd <= cmd;
		if (state == s_run && sel_write && enc_nparams != 3'd4)
			enc_params[enc_nparams[1:0]] <= sel_param;
	end

endmodule

`default_nettype wire

// ==== hw/vlq_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module vlq_encoder import cmd_pkg::*; (
	input logic clk,
	input logic rst,
	input arg_t params [4],
	input logic [2:0] nparams,
	input logic start,
	output logic busy,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	input logic send_ring_full,
	output logic [7:0] send_fifo_data,
	output logic send_fifo_wr_en,
	input logic send_fifo_full
);

	typedef enum logic [2:0] {
		e_idle,
		e_raw,
		e_load,
		e_send,
		e_len
	} state_e;

	state_e state;
	logic [2:0] idx;
	logic [2:0] rem;
	logic [2:0] vlq_len;
	logic [7:0] count;
	logic ring_pend;
	logic fifo_pend;
	logic ring_free;
	logic signed [31:0] val;
	logic [34:0] ext;

	assign busy = state != e_idle;
	// a byte waits in the output register until the ring has room
	assign send_ring_wr_en = ring_pend && !send_ring_full;
	assign send_fifo_wr_en = fifo_pend && !send_fifo_full;
	assign ring_free = !ring_pend || !send_ring_full;
	assign val = params[idx[1:0]];
	assign ext = {{3{val[31]}}, val};

	// shortest form, 7 bits per byte with the sign in the top group
	always_comb begin
		if (val >= -32 && val < 96)
			vlq_len = 3'd1;
		else if (val >= -4096 && val < 12288)
			vlq_len = 3'd2;
		else if (val >= -524288 && val < 1572864)
			vlq_len = 3'd3;
		else if (val >= -67108864 && val < 201326592)
			vlq_len = 3'd4;
		else
			vlq_len = 3'd5;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= e_idle;
			ring_pend <= 1'b0;
			fifo_pend <= 1'b0;
			idx <= '0;
			rem <= '0;
			count <= '0;
		end else begin
			if (send_ring_wr_en)
				ring_pend <= 1'b0;
			case (state)
				e_idle: begin
					if (start) begin
						idx <= '0;
						count <= '0;
						state <= (nparams == 3'd0) ? e_len : e_raw;
					end
				end
				// response id goes out as a plain byte
				e_raw: begin
					if (ring_free) begin
						ring_pend <= 1'b1;
						count <= count + 8'd1;
						idx <= 3'd1;
						state <= (nparams == 3'd1) ? e_len : e_load;
					end
				end
				e_load: begin
					rem <= vlq_len;
					state <= e_send;
				end
				e_send: begin
					if (ring_free) begin
						ring_pend <= 1'b1;
						count <= count + 8'd1;
						rem <= rem - 3'd1;
						if (rem == 3'd1 && idx + 3'd1 == nparams) begin
							state <= e_len;
						end else if (rem == 3'd1) begin
							idx <= idx + 3'd1;
							state <= e_load;
						end
					end
				end
				// length only after the last byte left
				e_len: begin
					if (!ring_pend && !fifo_pend)
						fifo_pend <= 1'b1;
					if (send_fifo_wr_en) begin
						fifo_pend <= 1'b0;
						state <= e_idle;
					end
				end
				default: state <= e_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == e_raw && ring_free)
			send_ring_data <= params[0][7:0];
		if (state == e_send && ring_free)
			send_ring_data <= {rem != 3'd1, ext[7*(rem-3'd1) +: 7]};
		if (state == e_len && !ring_pend && !fifo_pend)
			send_fifo_data <= count;
	end

endmodule

`default_nettype wire

// ==== hw/system_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module system_unit import cmd_pkg::*; #(
	parameter arg_t VERSION = 32'h0
) (
	input logic clk,
	input logic rst,
	input cmd_e ucmd,
	input logic cmd_ready,
	input arg_t systime,
	output logic arg_advance,
	output arg_t param_data,
	output logic param_write,
	output logic cmd_done,
	output logic shutdown
);

	typedef enum logic [1:0] {
		st_idle,
		st_id,
		st_val
	} state_e;

	state_e state;
	rsp_e rsp;
	arg_t value;

	// none of these commands take arguments
	assign arg_advance = 1'b0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			param_write <= 1'b0;
			cmd_done <= 1'b0;
			shutdown <= 1'b0;
		end else begin
			param_write <= 1'b0;
			cmd_done <= 1'b0;
			case (state)
				st_idle: begin
					if (cmd_ready) begin
						case (ucmd)
							cmd_get_version, cmd_get_time: state <= st_id;
							cmd_shutdown: begin
								shutdown <= 1'b1;
								cmd_done <= 1'b1;
							end
							default: cmd_done <= 1'b1;
						endcase
					end
				end
				st_id: begin
					param_write <= 1'b1;
					state <= st_val;
				end
				st_val: begin
					param_write <= 1'b1;
					cmd_done <= 1'b1;
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		// time is taken when the command arrives
		if (state == st_idle && cmd_ready) begin
			rsp <= (ucmd == cmd_get_time) ? rsp_get_time : rsp_get_version;
			value <= (ucmd == cmd_get_time) ? systime : VERSION;
		end
		if (state == st_id)
			param_data <= {24'd0, rsp};
		if (state == st_val)
			param_data <= value;
	end

endmodule

`default_nettype wire

// ==== hw/gpio_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_unit import cmd_pkg::*; #(
	parameter int NGPIO = 8
) (
	input logic clk,
	input logic rst,
	input cmd_e ucmd,
	input logic cmd_ready,
	input arg_t uarg,
	input logic shutdown,
	output logic arg_advance,
	output arg_t param_data,
	output logic param_write,
	output logic cmd_done,
	output logic [NGPIO-1:0] gpio
);

	localparam int PIN_BITS = (NGPIO > 1) ? $clog2(NGPIO) : 1;

	typedef enum logic [1:0] {
		st_idle,
		st_adv,
		st_exec
	} state_e;

	state_e state;
	arg_t pin;
	logic pin_ok;
	logic level;
	logic [NGPIO-1:0] dflt;
	logic [NGPIO-1:0] out_q;

	assign pin_ok = pin < NGPIO;
	assign level = uarg != '0;
	// shutdown drives every pin to its configured default
	assign gpio = shutdown ? dflt : out_q;
	assign param_data = '0;
	assign param_write = 1'b0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			arg_advance <= 1'b0;
			cmd_done <= 1'b0;
			dflt <= '0;
			out_q <= '0;
		end else begin
			arg_advance <= 1'b0;
			cmd_done <= 1'b0;
			case (state)
				st_idle: begin
					if (cmd_ready && (ucmd == cmd_config_digital_out ||
							ucmd == cmd_set_digital_out)) begin
						arg_advance <= 1'b1;
						state <= st_adv;
					end else if (cmd_ready) begin
						cmd_done <= 1'b1;
					end
				end
				// second argument shows on uarg one cycle later
				st_adv: state <= st_exec;
				st_exec: begin
					if (pin_ok && ucmd == cmd_config_digital_out) begin
						dflt[pin[PIN_BITS-1:0]] <= level;
						out_q[pin[PIN_BITS-1:0]] <= level;
					end
					if (pin_ok && ucmd == cmd_set_digital_out && !shutdown)
						out_q[pin[PIN_BITS-1:0]] <= level;
					cmd_done <= 1'b1;
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && cmd_ready)
			pin <= uarg;
	end

endmodule

`default_nettype wire

// ==== hw/cmd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_top import cmd_pkg::*; #(
	parameter int NGPIO = 8,
	parameter arg_t VERSION = 32'h0001_0203
) (
	input logic clk,
	input logic rst,
	input logic [7:0] msg_data,
	input logic msg_ready,
	output logic msg_rd_en,
	output logic [7:0] send_ring_data,
	output logic send_ring_wr_en,
	input logic send_ring_full,
	output logic [7:0] send_fifo_data,
	output logic send_fifo_wr_en,
	input logic send_fifo_full,
	input arg_t systime,
	output logic [NGPIO-1:0] gpio
);

	cmd_e dec_cmd;
	cmd_entry_t dec_entry;
	arg_t dec_arg;
	logic dec_arg_valid;
	logic dec_cmd_valid;
	logic disp_busy;
	cmd_e ucmd;
	arg_t uarg;
	logic sys_cmd_ready;
	logic gpio_cmd_ready;
	logic sys_arg_advance;
	logic gpio_arg_advance;
	arg_t sys_param_data;
	arg_t gpio_param_data;
	logic sys_param_write;
	logic gpio_param_write;
	logic sys_cmd_done;
	logic gpio_cmd_done;
	arg_t enc_params [4];
	logic [2:0] enc_nparams;
	logic enc_start;
	logic enc_busy;
	logic shutdown;

	vlq_decoder vlq_decoder_inst (
		.clk(clk), .rst(rst),
		.msg_data(msg_data), .msg_ready(msg_ready), .msg_rd_en(msg_rd_en),
		.busy(disp_busy), .cmd(dec_cmd), .entry(dec_entry),
		.arg_data(dec_arg), .arg_valid(dec_arg_valid), .cmd_valid(dec_cmd_valid)
	);

	cmd_dispatch cmd_dispatch_inst (
		.clk(clk), .rst(rst),
		.cmd(dec_cmd), .entry(dec_entry), .arg_data(dec_arg),
		.arg_valid(dec_arg_valid), .cmd_valid(dec_cmd_valid), .busy(disp_busy),
		.ucmd(ucmd), .uarg(uarg),
		.sys_cmd_ready(sys_cmd_ready), .gpio_cmd_ready(gpio_cmd_ready),
		.sys_arg_advance(sys_arg_advance), .gpio_arg_advance(gpio_arg_advance),
		.sys_param_data(sys_param_data), .gpio_param_data(gpio_param_data),
		.sys_param_write(sys_param_write), .gpio_param_write(gpio_param_write),
		.sys_cmd_done(sys_cmd_done), .gpio_cmd_done(gpio_cmd_done),
		.enc_params(enc_params), .enc_nparams(enc_nparams),
		.enc_start(enc_start), .enc_busy(enc_busy)
	);

	vlq_encoder vlq_encoder_inst (
		.clk(clk), .rst(rst),
		.params(enc_params), .nparams(enc_nparams), .start(enc_start), .busy(enc_busy),
		.send_ring_data(send_ring_data), .send_ring_wr_en(send_ring_wr_en),
		.send_ring_full(send_ring_full),
		.send_fifo_data(send_fifo_data), .send_fifo_wr_en(send_fifo_wr_en),
		.send_fifo_full(send_fifo_full)
	);

	system_unit #(.VERSION(VERSION)) system_unit_inst (
		.clk(clk), .rst(rst),
		.ucmd(ucmd), .cmd_ready(sys_cmd_ready), .systime(systime),
		.arg_advance(sys_arg_advance), .param_data(sys_param_data),
		.param_write(sys_param_write), .cmd_done(sys_cmd_done), .shutdown(shutdown)
	);

	gpio_unit #(.NGPIO(NGPIO)) gpio_unit_inst (
		.clk(clk), .rst(rst),
		.ucmd(ucmd), .cmd_ready(gpio_cmd_ready), .uarg(uarg), .shutdown(shutdown),
		.arg_advance(gpio_arg_advance), .param_data(gpio_param_data),
		.param_write(gpio_param_write), .cmd_done(gpio_cmd_done), .gpio(gpio)
	);

endmodule

`default_nettype wire

// ==== sim/cmd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_tb import cmd_pkg::*; ();

	localparam int NGPIO = 8;
	localparam arg_t VERSION = 32'h0203_0405;
	localparam int TIMEOUT = 400;

	typedef logic [7:0] byte_q_t [$];

	logic clk = 1'b0;
	logic rst;
	logic [7:0] msg_data;
	logic msg_ready;
	logic msg_rd_en;
	logic [7:0] send_ring_data;
	logic send_ring_wr_en;
	logic send_ring_full;
	logic [7:0] send_fifo_data;
	logic send_fifo_wr_en;
	logic send_fifo_full;
	arg_t systime;
	logic [NGPIO-1:0] gpio;

	int seed;
	byte_q_t host_q;
	byte_q_t exp_q;
	byte_q_t got_q;
	bit pop_req;
	bit stall_en;
	bit exp_armed;
	bit rsp_done;
	bit shut_m;
	logic [NGPIO-1:0] dflt_m;
	logic [NGPIO-1:0] out_m;
	logic [31:0] stall_rnd;

	cmd_top #(.NGPIO(NGPIO), .VERSION(VERSION)) cmd_top_inst (
		.clk(clk), .rst(rst),
		.msg_data(msg_data), .msg_ready(msg_ready), .msg_rd_en(msg_rd_en),
		.send_ring_data(send_ring_data), .send_ring_wr_en(send_ring_wr_en),
		.send_ring_full(send_ring_full),
		.send_fifo_data(send_fifo_data), .send_fifo_wr_en(send_fifo_wr_en),
		.send_fifo_full(send_fifo_full),
		.systime(systime), .gpio(gpio)
	);

	always #5 clk = ~clk;

	// expected bytes in shortest length with the msb group first
	function automatic byte_q_t vlq_encode(input arg_t value);
		byte_q_t q;
		int len;
		longint v;
		longint span;
		v = longint'($signed(value));
		len = 5;
		for (int n = 4; n >= 1; n--) begin
			span = longint'(1) << (7 * n - 2);
			if (v >= -span && v < 3 * span)
				len = n;
		end
		for (int i = len - 1; i >= 0; i--)
			q.push_back({i != 0, 7'(v >>> (7 * i))});
		return q;
	endfunction

	// random value inside one length band of either sign
	function automatic arg_t band_value(input int band, input bit neg, input logic [31:0] r);
		longint lo;
		longint hi;
		longint v;
		if (neg) begin
			lo = (band == 0) ? 1 : (longint'(1) << (7 * band - 2)) + 1;
			hi = (band == 4) ? (longint'(1) << 31) : (longint'(1) << (7 * band + 5));
		end else begin
			lo = (band == 0) ? 0 : longint'(3) << (7 * band - 2);
			hi = (band == 4) ? (longint'(1) << 31) - 1 : (longint'(3) << (7 * band + 5)) - 1;
		end
		v = lo + longint'({32'd0, r}) % (hi - lo + 1);
		return neg ? arg_t'(-v) : arg_t'(v);
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_bytes(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			stop_run($sformatf("Error at %0t ns: %s is %02h, expected %02h",
				$time, what, got, exp));
	endtask

	task automatic check_gpio(input logic [NGPIO-1:0] got, input logic [NGPIO-1:0] exp,
			input string what);
		if (got !== exp)
			stop_run($sformatf("Error at %0t ns: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	// padding adds a leading group that does not change the value
	task automatic queue_arg(input arg_t value, input bit pad);
		byte_q_t enc;
		enc = vlq_encode(value);
		if (pad)
			host_q.push_back(value[31] ? 8'hff : 8'h80);
		foreach (enc[i])
			host_q.push_back(enc[i]);
	endtask

	task automatic run_query(input cmd_e cmd, input arg_t value, input string what);
		byte_q_t enc;
		int cycles;
		@(posedge clk);
		#2;
		enc = vlq_encode(value);
		exp_q.delete();
		exp_q.push_back(cmd == cmd_get_time ? 8'd1 : 8'd0);
		foreach (enc[i])
			exp_q.push_back(enc[i]);
		exp_armed = 1'b1;
		rsp_done = 1'b0;
		if (cmd == cmd_get_time)
			systime = value;
		host_q.push_back(8'(cmd));
		cycles = 0;
		while (!rsp_done && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (!rsp_done)
			stop_run($sformatf("timeout: no response to %s within %0d cycles", what, TIMEOUT));
		exp_armed = 1'b0;
	endtask

	task automatic send_gpio(input cmd_e cmd, input arg_t pin, input arg_t value, input bit pad);
		@(posedge clk);
		#2;
		host_q.push_back(8'(cmd));
		queue_arg(pin, pad);
		queue_arg(value, pad);
		if (pin < NGPIO && cmd == cmd_config_digital_out) begin
			dflt_m[pin] = value != '0;
			out_m[pin] = value != '0;
		end else if (pin < NGPIO && !shut_m) begin
			out_m[pin] = value != '0;
		end
		// commands run in order, so a reply here means the gpio command is done
		run_query(cmd_get_version, VERSION, "version after gpio command");
		check_gpio(gpio, shut_m ? dflt_m : out_m, "gpio");
	endtask

	// the host FIFO drops its head byte on the edge where msg_rd_en is high
	always @(negedge clk) begin
		if (msg_rd_en === 1'b1 && pop_req)
			stop_run("host FIFO read on two cycles in a row");
		if (msg_rd_en === 1'b1 && host_q.size() == 0)
			stop_run("host FIFO read while it held no byte");
		pop_req = msg_rd_en === 1'b1;
	end

	always @(posedge clk) begin
		#1;
		if (pop_req && host_q.size() != 0)
			void'(host_q.pop_front());
		stall_rnd = $random(seed);
		send_ring_full = stall_en && stall_rnd[2];
		send_fifo_full = stall_en && stall_rnd[3];
		msg_ready = host_q.size() != 0 && !(stall_en && stall_rnd[1:0] == 2'd0);
		msg_data = (host_q.size() != 0) ? host_q[0] : 8'h00;
	end

	always @(negedge clk) begin
		if (!rst) begin
			if (send_ring_wr_en && send_ring_full)
				stop_run("ring write seen while the ring was full");
			if (send_fifo_wr_en && send_fifo_full)
				stop_run("length write seen while the length FIFO was full");
			if (send_ring_wr_en)
				got_q.push_back(send_ring_data);
			if (send_fifo_wr_en) begin
				if (!exp_armed)
					stop_run("a response arrived when none was expected");
				check_bytes(8'(got_q.size()), 8'(exp_q.size()), "response byte count");
				check_bytes(send_fifo_data, 8'(exp_q.size()), "posted length");
				foreach (exp_q[i])
					check_bytes(got_q[i], exp_q[i], $sformatf("response byte %0d", i));
				got_q.delete();
				rsp_done = 1'b1;
			end
		end
	end

	initial begin
		logic [31:0] pick;
		arg_t pin;
		arg_t level;
		seed = 3;
		rst = 1'b1;
		msg_data = 8'h00;
		msg_ready = 1'b0;
		send_ring_full = 1'b0;
		send_fifo_full = 1'b0;
		systime = '0;
		stall_en = 1'b0;
		exp_armed = 1'b0;
		rsp_done = 1'b0;
		shut_m = 1'b0;
		dflt_m = '0;
		out_m = '0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#2;
		check_gpio(gpio, '0, "gpio after reset");
		run_query(cmd_get_version, VERSION, "get_version");

		// second pass adds ring, length and host stalls
		for (int pass = 0; pass < 2; pass++) begin
			stall_en = pass != 0;
			for (int band = 0; band < 5; band++) begin
				run_query(cmd_get_time, band_value(band, 1'b0, $random(seed)), "get_time");
				run_query(cmd_get_time, band_value(band, 1'b1, $random(seed)), "get_time");
			end
			for (int n = 0; n < 16; n++) begin
				pick = $random(seed);
				if (pick[4:0] == 5'd0)
					pin = arg_t'(-3);
				else
					pin = arg_t'(pick[15:8] % (NGPIO + 3));
				if (pick[21:20] == 2'd0)
					level = '0;
				else
					level = band_value(pick[18:16] % 5, pick[19], $random(seed));
				send_gpio(pick[23] ? cmd_config_digital_out : cmd_set_digital_out,
					pin, level, pick[22]);
			end
		end

		@(posedge clk);
		#2;
		host_q.push_back(8'(cmd_shutdown));
		shut_m = 1'b1;
		run_query(cmd_get_version, VERSION, "version after shutdown");
		check_gpio(gpio, dflt_m, "gpio after shutdown");
		for (int n = 0; n < 6; n++) begin
			pick = $random(seed);
			send_gpio(cmd_set_digital_out, arg_t'(pick[2:0]), arg_t'(!dflt_m[pick[2:0]]),
				pick[3]);
		end
		check_gpio(gpio, dflt_m, "gpio held at defaults");
		run_query(cmd_get_time, band_value(4, 1'b1, $random(seed)), "get_time after shutdown");

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/cmd_pkg.sv
hw/vlq_decoder.sv
hw/cmd_dispatch.sv
hw/vlq_encoder.sv
hw/system_unit.sv
hw/gpio_unit.sv
hw/cmd_top.sv
sim/cmd_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary -Wno-fatal --top-module cmd_tb -f compile.f -o cmd_tb_sim \
	&& ./obj_dir/cmd_tb_sim | tee /dev/stderr | grep "PASS: all tests" > /dev/null \
	&& echo "simulation passed" || { echo "simulation failed"; exit 1; }
